/* icache_top.f */
+incdir+common
common/icache_pkg.sv
common/icache_way_if.sv
icache/icache_way.sv
icache/icache_lru.sv
icache/icache_ctrl.sv
hdl/icache_top.sv
verification/icache_asserts.sv
verification/icache_tb.sv

/* Makefile */
SIM  = obj_dir/Vicache_tb
SRCS = $(shell grep -v '^+' icache_top.f) common/icache_params.svh

.PHONY: all run clean

all: run

$(SIM): icache_top.f $(SRCS)
	verilator --binary --timing --assert --top-module icache_tb -f icache_top.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/icache_tb.sv */
/*
 * testbench for the two-way instruction cache
 * clock, reset, seeded random fetches, memory responder,
 * reference cache model, checker and watchdog
 */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_tb;

    localparam int N_RANDOM = 400;
    localparam int N_REQ    = N_RANDOM + 16;
    // worst case per request is 6 memory cycles plus 4 of overhead
    localparam int LIMIT_NS = N_REQ * (6 + 4) * 20 + 2000;

    logic                       clk;
    logic                       rst;
    logic [`ICACHE_ADDR_W-1:0]  i_inst_addr;
    logic                       i_inst_ena;
    logic [`ICACHE_DATA_W-1:0]  o_inst_data;
    logic                       o_inst_valid;
    logic                       o_mem_req;
    logic [`ICACHE_ADDR_W-1:0]  o_mem_addr;
    logic [`ICACHE_DATA_W-1:0]  i_mem_data;
    logic                       i_mem_ok;

    integer                     seed;
    int                         error_count;

    // reference model, two ways per set
    logic                       m_valid [`ICACHE_SETS][2];
    logic [`ICACHE_TAG_W-1:0]   m_tag   [`ICACHE_SETS][2];
    int                         m_age   [`ICACHE_SETS][2];

    logic [`ICACHE_TAG_W-1:0]   tag_pool [4];
    logic [`ICACHE_INDEX_W-1:0] idx_pool [8];

    icache_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .i_inst_addr  (i_inst_addr),
        .i_inst_ena   (i_inst_ena),
        .o_inst_data  (o_inst_data),
        .o_inst_valid (o_inst_valid),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_data   (i_mem_data),
        .i_mem_ok     (i_mem_ok)
    );

    always #10 clk = ~clk;

    // memory contents, a scramble of addr[63:3]
    function automatic logic [31:0] mem_word(input logic [63:0] addr);
        return addr[34:3] ^ {addr[63:35], 3'b101} ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [63:0] make_addr(input logic [54:0] tag, input logic [5:0] idx);
        return {tag, idx, 3'b000};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic model_reset();
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_age[s][w]   = 0;
            end
        end
    endtask

    // updates the model and returns 1 on a predicted hit
    function automatic logic model_access(input logic [63:0] addr);
        int                        idx;
        logic [`ICACHE_TAG_W-1:0]  tag;
        int                        hit_way;
        int                        way;
        idx     = int'(addr[8:3]);
        tag     = addr[63:9];
        hit_way = -1;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (m_age[s][w] < 7) begin
                    m_age[s][w]++;
                end
            end
        end
        for (int w = 0; w < 2; w++) begin
            if (hit_way < 0 && m_valid[idx][w] && m_tag[idx][w] == tag) begin
                hit_way = w;
            end
        end
        if (hit_way >= 0) begin
            m_age[idx][hit_way] = 0;
            return 1'b1;
        end
        if (!m_valid[idx][0]) begin
            way = 0;
        end else if (!m_valid[idx][1]) begin
            way = 1;
        end else if (m_age[idx][0] >= m_age[idx][1]) begin
            way = 0;
        end else begin
            way = 1;
        end
        m_valid[idx][way] = 1'b1;
        m_tag[idx][way]   = tag;
        m_age[idx][way]   = 0;
        return 1'b0;
    endfunction

    // called right after a rising edge with the cache idle
    task automatic fetch(input logic [63:0] addr, input string test);
        logic        exp_hit;
        logic [31:0] word;
        bit          saw_req;
        bit          ok_sent;
        int          wait_left;
        int          cycles;
        int          ok_cycle;
        exp_hit   = model_access(addr);
        word      = mem_word(addr);
        saw_req   = 1'b0;
        ok_sent   = 1'b0;
        wait_left = 0;
        cycles    = 0;
        ok_cycle  = 0;
        i_inst_addr <= addr;
        i_inst_ena  <= 1'b1;
        @(posedge clk);
        i_inst_ena <= 1'b0;
        do begin
            @(posedge clk);
            cycles++;
            i_mem_ok <= 1'b0;
            if (o_mem_req && !ok_sent) begin
                if (!saw_req) begin
                    saw_req   = 1'b1;
                    wait_left = 1 + int'($unsigned($random(seed)) % 6);
                end
                check_value({test, " mem addr"}, addr, o_mem_addr);
                wait_left--;
                if (wait_left == 0) begin
                    i_mem_ok   <= 1'b1;
                    i_mem_data <= word;
                    ok_sent    = 1'b1;
                    ok_cycle   = cycles;
                end
            end
        end while (!o_inst_valid);
        check_value({test, " miss"}, 64'(!exp_hit), 64'(saw_req));
        check_value({test, " data"}, 64'(word), 64'(o_inst_data));
        if (exp_hit) begin
            check_value({test, " hit latency"}, 64'd2, 64'(cycles));
        end else begin
            // mem_ok sampled one edge after driving, valid one edge later
            check_value({test, " fill latency"}, 64'(ok_cycle + 2), 64'(cycles));
        end
    endtask

    task automatic apply_reset();
        rst        <= 1'b0;
        i_inst_ena <= 1'b0;
        i_mem_ok   <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        model_reset();
        check_value("reset inst_valid", 64'd0, 64'(o_inst_valid));
        check_value("reset mem_req", 64'd0, 64'(o_mem_req));
    endtask

    initial begin
        #(LIMIT_NS);
        $display("timeout: the cache did not finish all requests in %0d ns", LIMIT_NS);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [63:0] tmp;
        logic [31:0] r;
        logic [63:0] addr_a;
        logic [63:0] addr_b;
        logic [63:0] addr_c;
        clk         = 1'b0;
        rst         = 1'b0;
        i_inst_addr = '0;
        i_inst_ena  = 1'b0;
        i_mem_data  = '0;
        i_mem_ok    = 1'b0;
        seed        = 32'hafa9;
        error_count = 0;
        apply_reset();

        for (int i = 0; i < 4; i++) begin
            tmp         = {$random(seed), $random(seed)};
            tag_pool[i] = tmp[54:0];
        end
        for (int i = 0; i < 8; i++) begin
            idx_pool[i] = 6'(i * 7 + 3);
        end

        // three tags fighting over set 20
        addr_a = make_addr(55'h1, 6'd20);
        addr_b = make_addr(55'h2, 6'd20);
        addr_c = make_addr(55'h3, 6'd20);
        fetch(addr_a, "first miss");
        fetch(addr_a, "repeat hit");
        fetch(addr_b, "replace b");
        fetch(addr_a, "replace a");
        fetch(addr_c, "replace c");
        fetch(addr_a, "replace a again");
        fetch(addr_b, "replace b again");

        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            fetch(make_addr(tag_pool[r[1:0]], idx_pool[r[4:2]]), "random");
        end

        apply_reset();
        fetch(addr_a, "after reset");
        fetch(addr_a, "after reset hit");

        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verification/icache_asserts.sv */
/*
 * protocol assertions bound to the cache top level
 * response pulse and fill timing, memory request hold and address,
 * exclusivity
 */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_asserts (
    input logic                      clk,
    input logic                      rst,
    input logic                      i_inst_valid,
    input logic                      i_mem_req,
    input logic [`ICACHE_ADDR_W-1:0] i_mem_addr,
    input logic                      i_mem_ok,
    input icache_pkg::icache_state_e i_state
);

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst)
        i_inst_valid |=> !i_inst_valid)
        else $error("o_inst_valid high on two consecutive edges");

    // request held until memory answers
    a_req_hold: assert property (@(posedge clk) disable iff (!rst)
        i_mem_req && !i_mem_ok |=> i_mem_req)
        else $error("o_mem_req dropped before i_mem_ok");

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst)
        i_mem_req && !i_mem_ok |=> i_mem_addr == $past(i_mem_addr))
        else $error("o_mem_addr changed while o_mem_req was high");

    a_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(i_mem_req && i_inst_valid))
        else $error("o_mem_req and o_inst_valid high together");

    // refill completion answers on the next edge
    a_fill_answer: assert property (@(posedge clk) disable iff (!rst)
        (i_state == icache_pkg::REFILL) && i_mem_ok |=> i_inst_valid)
        else $error("o_inst_valid missing one cycle after i_mem_ok");

endmodule

bind icache_top icache_asserts asserts_i (
    .clk          (clk),
    .rst          (rst),
    .i_inst_valid (o_inst_valid),
    .i_mem_req    (o_mem_req),
    .i_mem_addr   (o_mem_addr),
    .i_mem_ok     (i_mem_ok),
    .i_state      (ctrl_i.state_q)
);

/* hdl/icache_top.sv */
/*
 * two-way instruction cache top level
 * controller, two ways and age tracker
 */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`ICACHE_ADDR_W-1:0]  i_inst_addr,
    input  logic                       i_inst_ena,
    output logic [`ICACHE_DATA_W-1:0]  o_inst_data,
    output logic                       o_inst_valid,
    output logic                       o_mem_req,
    output logic [`ICACHE_ADDR_W-1:0]  o_mem_addr,
    input  logic [`ICACHE_DATA_W-1:0]  i_mem_data,
    input  logic                       i_mem_ok
);

    icache_way_if way0_if ();
    icache_way_if way1_if ();

    logic [`ICACHE_INDEX_W-1:0] age_index;
    logic                       age_tick;
    logic                       touch;
    icache_pkg::icache_way_e    touch_way;
    logic                       valid0;
    logic                       valid1;
    icache_pkg::icache_way_e    victim;

    icache_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .i_inst_addr  (i_inst_addr),
        .i_inst_ena   (i_inst_ena),
        .o_inst_data  (o_inst_data),
        .o_inst_valid (o_inst_valid),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_data   (i_mem_data),
        .i_mem_ok     (i_mem_ok),
        .way0         (way0_if.ctrl),
        .way1         (way1_if.ctrl),
        .o_age_index  (age_index),
        .o_age_tick   (age_tick),
        .o_touch      (touch),
        .o_touch_way  (touch_way),
        .o_valid0     (valid0),
        .o_valid1     (valid1),
        .i_victim     (victim)
    );

    icache_way way0_i (
        .clk  (clk),
        .rst  (rst),
        .port (way0_if.way)
    );

    icache_way way1_i (
        .clk  (clk),
        .rst  (rst),
        .port (way1_if.way)
    );

    icache_lru lru_i (
        .clk         (clk),
        .rst         (rst),
        .i_index     (age_index),
        .i_tick      (age_tick),
        .i_touch     (touch),
        .i_touch_way (touch_way),
        .i_valid0    (valid0),
        .i_valid1    (valid1),
        .o_victim    (victim)
    );

endmodule

/* icache/icache_ctrl.sv */
/*
 * instruction cache controller
 * lookup/refill FSM, tag compare, memory request, fetch response
 */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`ICACHE_ADDR_W-1:0]   i_inst_addr,
    input  logic                        i_inst_ena,
    output logic [`ICACHE_DATA_W-1:0]   o_inst_data,
    output logic                        o_inst_valid,
    output logic                        o_mem_req,
    output logic [`ICACHE_ADDR_W-1:0]   o_mem_addr,
    input  logic [`ICACHE_DATA_W-1:0]   i_mem_data,
    input  logic                        i_mem_ok,
    icache_way_if.ctrl                  way0,
    icache_way_if.ctrl                  way1,
    output logic [`ICACHE_INDEX_W-1:0]  o_age_index,
    output logic                        o_age_tick,
    output logic                        o_touch,
    output icache_pkg::icache_way_e     o_touch_way,
    output logic                        o_valid0,
    output logic                        o_valid1,
    input  icache_pkg::icache_way_e     i_victim
);

    localparam int IDX_LO = 3;
    localparam int IDX_HI = IDX_LO + `ICACHE_INDEX_W - 1;
    localparam int TAG_LO = IDX_HI + 1;

    icache_pkg::icache_state_e state_q;
    icache_pkg::icache_state_e state_d;

    logic [`ICACHE_ADDR_W-1:0]  addr_q;
    logic [`ICACHE_DATA_W-1:0]  data_q;
    logic [`ICACHE_INDEX_W-1:0] cur_index;
    logic [`ICACHE_TAG_W-1:0]   req_tag;
    logic                       accept;
    logic                       hit0;
    logic                       hit1;
    logic                       hit;
    logic                       fill_done;

    assign accept    = (state_q == icache_pkg::IDLE) && i_inst_ena;
    assign fill_done = (state_q == icache_pkg::REFILL) && i_mem_ok;

    // live address in IDLE so the way reads start at the accepting edge
    assign cur_index = (state_q == icache_pkg::IDLE) ? i_inst_addr[IDX_HI:IDX_LO]
                                                     : addr_q[IDX_HI:IDX_LO];
    assign req_tag   = addr_q[`ICACHE_ADDR_W-1:TAG_LO];

    assign hit0 = way0.rd_valid && (way0.rd_tag == req_tag);
    assign hit1 = way1.rd_valid && (way1.rd_tag == req_tag);
    assign hit  = hit0 || hit1;

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE: begin
                if (i_inst_ena) begin
                    state_d = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::LOOKUP: begin
                state_d = hit ? icache_pkg::HIT : icache_pkg::REFILL;
            end
            icache_pkg::REFILL: begin
                if (i_mem_ok) begin
                    state_d = icache_pkg::FILL;
                end
            end
            icache_pkg::HIT,
            icache_pkg::FILL: begin
                state_d = icache_pkg::IDLE;
            end
            default: begin
                state_d = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= icache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request address held for compare, refill and memory address
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_inst_addr;
        end
    end

    // response word, from the hit way or straight from memory
    always_ff @(posedge clk) begin
        if ((state_q == icache_pkg::LOOKUP) && hit) begin
            data_q <= hit0 ? way0.rd_data : way1.rd_data;
        end else if (fill_done) begin
            data_q <= i_mem_data;
        end
    end

    assign o_inst_data  = data_q;
    assign o_inst_valid = (state_q == icache_pkg::HIT) || (state_q == icache_pkg::FILL);
    assign o_mem_req    = (state_q == icache_pkg::REFILL);
    assign o_mem_addr   = addr_q;

    assign way0.index   = cur_index;
    assign way0.wr_en   = fill_done && (i_victim == icache_pkg::WAY0);
    assign way0.wr_tag  = req_tag;
    assign way0.wr_data = i_mem_data;

    assign way1.index   = cur_index;
    assign way1.wr_en   = fill_done && (i_victim == icache_pkg::WAY1);
    assign way1.wr_tag  = req_tag;
    assign way1.wr_data = i_mem_data;

    // age tick on accept, touch on hit or refill
    assign o_age_index = cur_index;
    assign o_age_tick  = accept;
    assign o_touch     = ((state_q == icache_pkg::LOOKUP) && hit) || fill_done;
    assign o_touch_way = (state_q == icache_pkg::LOOKUP)
                       ? (hit0 ? icache_pkg::WAY0 : icache_pkg::WAY1)
                       : i_victim;

    assign o_valid0 = way0.rd_valid;
    assign o_valid1 = way1.rd_valid;

endmodule

/* icache/icache_lru.sv */
/*
 * age tracker for the two ways
 * saturating age counters per set and victim selection
 */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_lru (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`ICACHE_INDEX_W-1:0]  i_index,
    input  logic                        i_tick,
    input  logic                        i_touch,
    input  icache_pkg::icache_way_e     i_touch_way,
    input  logic                        i_valid0,
    input  logic                        i_valid1,
    output icache_pkg::icache_way_e     o_victim
);

    localparam logic [`ICACHE_AGE_W-1:0] AGE_ONE = 1;
    localparam logic [`ICACHE_AGE_W-1:0] AGE_MAX = '1;

    logic [`ICACHE_AGE_W-1:0] age0 [`ICACHE_SETS];
    logic [`ICACHE_AGE_W-1:0] age1 [`ICACHE_SETS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                age0[s] <= '0;
                age1[s] <= '0;
            end
        end else if (i_tick) begin
            // every set ages on an accepted request
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                age0[s] <= (age0[s] == AGE_MAX) ? AGE_MAX : age0[s] + AGE_ONE;
                age1[s] <= (age1[s] == AGE_MAX) ? AGE_MAX : age1[s] + AGE_ONE;
            end
        end else if (i_touch) begin
            if (i_touch_way == icache_pkg::WAY0) begin
                age0[i_index] <= '0;
            end else begin
                age1[i_index] <= '0;
            end
        end
    end

    // empty ways first, then the older one, ties go to way 0
    always_comb begin
        if (!i_valid0) begin
            o_victim = icache_pkg::WAY0;
        end else if (!i_valid1) begin
            o_victim = icache_pkg::WAY1;
        end else if (age0[i_index] >= age1[i_index]) begin
            o_victim = icache_pkg::WAY0;
        end else begin
            o_victim = icache_pkg::WAY1;
        end
    end

endmodule

/* icache/icache_way.sv */
/*
 * one cache way
 * tag array, data array and valid bits with synchronous read
 */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_way (
    input  logic       clk,
    input  logic       rst,
    icache_way_if.way  port
);

    logic [`ICACHE_TAG_W-1:0]  tag_mem  [`ICACHE_SETS];
    logic [`ICACHE_DATA_W-1:0] data_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]   valid_q;

    // arrays and read registers, old contents on a same-edge write
    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            tag_mem[port.index]  <= port.wr_tag;
            data_mem[port.index] <= port.wr_data;
        end
        port.rd_tag  <= tag_mem[port.index];
        port.rd_data <= data_mem[port.index];
    end

    // valid bits follow the same read timing
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q       <= '0;
            port.rd_valid <= 1'b0;
        end else begin
            if (port.wr_en) begin
                valid_q[port.index] <= 1'b1;
            end
            port.rd_valid <= valid_q[port.index];
        end
    end

endmodule

/* common/icache_way_if.sv */
/*
 * bundle between the cache controller and one way
 * index and write controls from ctrl, read results from the way
 */
`timescale 1ns/1ps
`include "icache_params.svh"

interface icache_way_if;

    logic [`ICACHE_INDEX_W-1:0] index;
    logic                       wr_en;
    logic [`ICACHE_TAG_W-1:0]   wr_tag;
    logic [`ICACHE_DATA_W-1:0]  wr_data;

    // valid one cycle after index is captured
    logic                       rd_valid;
    logic [`ICACHE_TAG_W-1:0]   rd_tag;
    logic [`ICACHE_DATA_W-1:0]  rd_data;

    modport ctrl (
        output index,
        output wr_en,
        output wr_tag,
        output wr_data,
        input  rd_valid,
        input  rd_tag,
        input  rd_data
    );

    modport way (
        input  index,
        input  wr_en,
        input  wr_tag,
        input  wr_data,
        output rd_valid,
        output rd_tag,
        output rd_data
    );

endinterface

/* common/icache_pkg.sv */
/*
 * instruction cache types
 * controller state enum, way select enum
 */
package icache_pkg;

    // lookup/refill controller
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        HIT    = 3'd2,
        REFILL = 3'd3,
        FILL   = 3'd4
    } icache_state_e;

    // victim and touched way
    typedef enum logic {
        WAY0 = 1'b0,
        WAY1 = 1'b1
    } icache_way_e;

endpackage

/* common/icache_params.svh */
/*
 * instruction cache geometry
 * address, data, index, tag and age widths, set count
 */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// fetch address and instruction word
`define ICACHE_ADDR_W   64
`define ICACHE_DATA_W   32

// set index is addr[8:3], tag is addr[63:9]
`define ICACHE_INDEX_W  6
`define ICACHE_SETS     64
`define ICACHE_TAG_W    55

// saturates at all ones
`define ICACHE_AGE_W    3

`endif
